// File: common/rob_pkg.sv
package rob_pkg;

	// ##################################################
	// sizes
	// ##################################################

	localparam int lanes = 3; // superscalar width.

	localparam int rob_size = 32;
	localparam int rob_index_width = 5;

	localparam int arch_reg_count = 32;
	localparam int phys_reg_count = 64;

	localparam int pc_width = 32;

	// ##################################################
	// types
	// ##################################################

	// slot number in the ring.
	typedef logic [rob_index_width-1:0] rob_index_t;

	// occupancy, 0 to rob_size inclusive.
	typedef logic [rob_index_width:0] count_t;

	// number of lanes, 0 to 3.
	typedef logic [1:0] lane_count_t;

	typedef logic [$clog2(arch_reg_count)-1:0] arch_reg_t;
	typedef logic [$clog2(phys_reg_count)-1:0] phys_reg_t;

	typedef logic [pc_width-1:0] pc_t;

	// life of one slot: dispatched, then completed, then retired.
	typedef enum logic [1:0] {
		empty  = 2'd0,
		in_use = 2'd1,
		complete = 2'd2
	} rob_state_t;

endpackage

// File: rob/rob.sv
`timescale 1ns/10ps

module rob import rob_pkg::*; (
	input  logic clock,
	input  logic reset,

	// dispatch.
	input  lane_count_t dispatch_count,
	input  pc_t [lanes-1:0] dispatch_pc,
	input  logic [lanes-1:0] dispatch_dest_valid,
	input  arch_reg_t [lanes-1:0] dispatch_arch_reg,
	input  phys_reg_t [lanes-1:0] dispatch_preg,
	input  phys_reg_t [lanes-1:0] dispatch_told,
	output logic [lanes-1:0] struct_stall,
	output rob_index_t [lanes-1:0] alloc_index,

	// completion.
	input  logic [lanes-1:0] complete_valid,
	input  rob_index_t [lanes-1:0] complete_index,

	// retirement.
	output logic [lanes-1:0] retire_valid,
	output pc_t [lanes-1:0] retire_pc,
	output logic [lanes-1:0] retire_dest_valid,
	output arch_reg_t [lanes-1:0] retire_arch_reg,
	output phys_reg_t [lanes-1:0] retire_preg,
	output phys_reg_t [lanes-1:0] retire_told
);

	// ##################################################
	// storage
	// ##################################################

	pc_t slot_pc [rob_size];
	logic [rob_size-1:0] slot_dest_valid;
	arch_reg_t slot_arch_reg [rob_size];
	phys_reg_t slot_preg [rob_size];
	phys_reg_t slot_told [rob_size];

	rob_state_t slot_state [rob_size];

	rob_index_t head; // oldest entry.
	rob_index_t tail; // next free slot.
	count_t count;

	count_t free_slots;
	lane_count_t accept_count;
	lane_count_t retire_count;
	rob_index_t [lanes-1:0] retire_slot;

	// ##################################################
	// dispatch side
	// ##################################################

	// retirements in this cycle do not add space.
	assign free_slots = count_t'(rob_size) - count;

	always_comb begin
		if (count_t'(dispatch_count) > free_slots) begin
			accept_count = lane_count_t'(free_slots); // less than 3 here.
		end else begin
			accept_count = dispatch_count;
		end
	end

	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			alloc_index[i] = tail + rob_index_t'(i);
			struct_stall[i] = (lane_count_t'(i) < dispatch_count) &&
				(lane_count_t'(i) >= accept_count);
		end
	end

	// ##################################################
	// retire side
	// ##################################################

	// a lane retires only if every older lane does too.
	always_comb begin
		retire_count = '0;
		for (int j = 0; j < lanes; j++) begin
			retire_slot[j] = head + rob_index_t'(j);
			if (j == 0) begin
				retire_valid[j] = (slot_state[retire_slot[j]] == complete);
			end else begin
				retire_valid[j] = retire_valid[j-1] &&
					(slot_state[retire_slot[j]] == complete);
			end
			if (retire_valid[j]) begin
				retire_count = retire_count + lane_count_t'(1);
			end
		end
	end

	always_comb begin
		for (int j = 0; j < lanes; j++) begin
			retire_pc[j] = slot_pc[retire_slot[j]];
			retire_dest_valid[j] = slot_dest_valid[retire_slot[j]];
			retire_arch_reg[j] = slot_arch_reg[retire_slot[j]];
			retire_preg[j] = slot_preg[retire_slot[j]];
			retire_told[j] = slot_told[retire_slot[j]];
		end
	end

	// ##################################################
	// state update
	// ##################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			for (int s = 0; s < rob_size; s++) begin
				slot_state[s] <= empty;
			end
		end else begin
			for (int j = 0; j < lanes; j++) begin
				if (retire_valid[j]) begin
					slot_state[retire_slot[j]] <= empty;
				end
			end
			for (int i = 0; i < lanes; i++) begin
				if (lane_count_t'(i) < accept_count) begin
					slot_state[alloc_index[i]] <= in_use;
				end
			end
			// completion goes last.
			for (int i = 0; i < lanes; i++) begin
				if (complete_valid[i]) begin
					slot_state[complete_index[i]] <= complete;
				end
			end
			head <= head + rob_index_t'(retire_count);
			tail <= tail + rob_index_t'(accept_count);
			count <= count + count_t'(accept_count) - count_t'(retire_count);
		end
	end

	// payload of accepted lanes.
	always_ff @(posedge clock) begin
		for (int i = 0; i < lanes; i++) begin
			if (lane_count_t'(i) < accept_count) begin
				slot_pc[alloc_index[i]] <= dispatch_pc[i];
				slot_dest_valid[alloc_index[i]] <= dispatch_dest_valid[i];
				slot_arch_reg[alloc_index[i]] <= dispatch_arch_reg[i];
				slot_preg[alloc_index[i]] <= dispatch_preg[i];
				slot_told[alloc_index[i]] <= dispatch_told[i];
			end
		end
	end

	// ##################################################
	// assertions
	// ##################################################

	count_in_range: assert property (
		@(posedge clock) disable iff (reset)
		count <= count_t'(rob_size)
	);

	for (genvar i = 0; i < lanes; i++) begin : g_complete_check
		complete_in_use: assert property (
			@(posedge clock) disable iff (reset)
			complete_valid[i] |-> slot_state[complete_index[i]] == in_use
		);
	end

	// retiring lanes stay inside the occupied part of the ring.
	retire_contiguous: assert property (
		@(posedge clock) disable iff (reset)
		retire_valid inside {3'b000, 3'b001, 3'b011, 3'b111} &&
			$countones(retire_valid) <= int'(count)
	);

endmodule

// File: rtl/arch_map_table.sv
`timescale 1ns/10ps

module arch_map_table import rob_pkg::*; (
	input  logic clock,
	input  logic reset,

	// retiring lanes from the buffer.
	input  logic [lanes-1:0] retire_valid,
	input  logic [lanes-1:0] retire_dest_valid,
	input  arch_reg_t [lanes-1:0] retire_arch_reg,
	input  phys_reg_t [lanes-1:0] retire_preg,
	input  phys_reg_t [lanes-1:0] retire_told,

	// registers handed back to the free list.
	output logic [lanes-1:0] freed_valid,
	output phys_reg_t [lanes-1:0] freed_preg,

	// read port for recovery.
	input  arch_reg_t lookup_arch_reg,
	output phys_reg_t lookup_preg
);

	// ##################################################
	// committed map
	// ##################################################

	phys_reg_t map [arch_reg_count];

	logic [lanes-1:0] commit_write;

	assign commit_write = retire_valid & retire_dest_valid;

	// lanes in order, so a younger write to the same register wins.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < arch_reg_count; r++) begin
				map[r] <= phys_reg_t'(r); // identity.
			end
		end else begin
			for (int j = 0; j < lanes; j++) begin
				if (commit_write[j]) begin
					map[retire_arch_reg[j]] <= retire_preg[j];
				end
			end
		end
	end

	assign lookup_preg = map[lookup_arch_reg];

	// ##################################################
	// freed registers
	// ##################################################

	// told of a writing lane is no longer reachable once it commits.
	always_comb begin
		for (int j = 0; j < lanes; j++) begin
			freed_valid[j] = commit_write[j];
			freed_preg[j] = retire_told[j];
		end
	end

	for (genvar j = 0; j < lanes; j++) begin : g_freed_check
		freed_not_committed: assert property (
			@(posedge clock) disable iff (reset)
			freed_valid[j] |-> freed_preg[j] != retire_preg[j]
		);
	end

endmodule

// File: rtl/retire_subsystem.sv
`timescale 1ns/10ps

module retire_subsystem import rob_pkg::*; (
	input  logic clock,
	input  logic reset,

	// dispatch.
	input  lane_count_t dispatch_count,
	input  pc_t [lanes-1:0] dispatch_pc,
	input  logic [lanes-1:0] dispatch_dest_valid,
	input  arch_reg_t [lanes-1:0] dispatch_arch_reg,
	input  phys_reg_t [lanes-1:0] dispatch_preg,
	input  phys_reg_t [lanes-1:0] dispatch_told,
	output logic [lanes-1:0] struct_stall,
	output rob_index_t [lanes-1:0] alloc_index,

	// completion.
	input  logic [lanes-1:0] complete_valid,
	input  rob_index_t [lanes-1:0] complete_index,

	// retirement.
	output logic [lanes-1:0] retire_valid,
	output pc_t [lanes-1:0] retire_pc,
	output logic [lanes-1:0] retire_dest_valid,
	output arch_reg_t [lanes-1:0] retire_arch_reg,
	output phys_reg_t [lanes-1:0] retire_preg,
	output phys_reg_t [lanes-1:0] retire_told,

	// free list and map read.
	output logic [lanes-1:0] freed_valid,
	output phys_reg_t [lanes-1:0] freed_preg,
	input  arch_reg_t lookup_arch_reg,
	output phys_reg_t lookup_preg
);

	rob u_rob (
		.clock               (clock),
		.reset               (reset),
		.dispatch_count      (dispatch_count),
		.dispatch_pc         (dispatch_pc),
		.dispatch_dest_valid (dispatch_dest_valid),
		.dispatch_arch_reg   (dispatch_arch_reg),
		.dispatch_preg       (dispatch_preg),
		.dispatch_told       (dispatch_told),
		.struct_stall        (struct_stall),
		.alloc_index         (alloc_index),
		.complete_valid      (complete_valid),
		.complete_index      (complete_index),
		.retire_valid        (retire_valid),
		.retire_pc           (retire_pc),
		.retire_dest_valid   (retire_dest_valid),
		.retire_arch_reg     (retire_arch_reg),
		.retire_preg         (retire_preg),
		.retire_told         (retire_told)
	);

	// commits straight from the retire lanes, no extra stage.
	arch_map_table u_arch_map_table (
		.clock             (clock),
		.reset             (reset),
		.retire_valid      (retire_valid),
		.retire_dest_valid (retire_dest_valid),
		.retire_arch_reg   (retire_arch_reg),
		.retire_preg       (retire_preg),
		.retire_told       (retire_told),
		.freed_valid       (freed_valid),
		.freed_preg        (freed_preg),
		.lookup_arch_reg   (lookup_arch_reg),
		.lookup_preg       (lookup_preg)
	);

endmodule

// File: verification/rob_tb_model.svh
`ifndef ROB_TB_MODEL_SVH
`define ROB_TB_MODEL_SVH

// ##################################################
// reference model
// ##################################################

typedef struct packed {
	pc_t pc;
	logic dest_valid;
	arch_reg_t arch_reg;
	phys_reg_t preg;
	phys_reg_t told;
	rob_index_t index;
	logic done;
} model_entry_t;

model_entry_t model_queue [$]; // oldest first.
phys_reg_t model_map [arch_reg_count];
rob_index_t model_tail;

task automatic model_reset();
	model_queue.delete();
	for (int r = 0; r < arch_reg_count; r++) begin
		model_map[r] = phys_reg_t'(r);
	end
	model_tail = '0;
endtask

// space is taken from the occupancy at the start of the cycle.
function automatic int model_accept_count(input int offered);
	int free_slots;
	free_slots = rob_size - model_queue.size();
	if (offered > free_slots) begin
		return free_slots;
	end
	return offered;
endfunction

// done entries in a row from the oldest, at most one per lane.
function automatic int model_retire_count();
	int n;
	n = 0;
	while (n < lanes && n < model_queue.size() && model_queue[n].done) begin
		n++;
	end
	return n;
endfunction

task automatic model_complete(input rob_index_t index);
	for (int k = 0; k < model_queue.size(); k++) begin
		if (!model_queue[k].done && model_queue[k].index == index) begin
			model_queue[k].done = 1'b1;
		end
	end
endtask

// oldest first, so the younger write to a register wins.
task automatic model_retire(input int n);
	model_entry_t entry;
	for (int j = 0; j < n; j++) begin
		entry = model_queue.pop_front();
		if (entry.dest_valid) begin
			model_map[entry.arch_reg] = entry.preg;
		end
	end
endtask

task automatic model_dispatch(input model_entry_t entry);
	model_entry_t slot_entry;
	slot_entry = entry;
	slot_entry.index = model_tail;
	slot_entry.done = 1'b0;
	model_queue.push_back(slot_entry);
	model_tail = model_tail + rob_index_t'(1);
endtask

`endif

// File: verification/rob_tb.sv
`timescale 1ns/10ps

module rob_tb import rob_pkg::*; ();

	localparam int clock_period = 10;
	localparam int reset_cycles = 5;
	localparam int run_cycles = 3000;
	localparam int timeout_cycles = 3200;
	localparam int fill_start = 1200; // completions held back here.
	localparam int fill_end = 1450;
	localparam logic [31:0] seed = 32'h2d16_7f4d;

	logic clock;
	logic reset;
	lane_count_t dispatch_count;
	pc_t [lanes-1:0] dispatch_pc;
	logic [lanes-1:0] dispatch_dest_valid;
	arch_reg_t [lanes-1:0] dispatch_arch_reg;
	phys_reg_t [lanes-1:0] dispatch_preg;
	phys_reg_t [lanes-1:0] dispatch_told;
	logic [lanes-1:0] struct_stall;
	rob_index_t [lanes-1:0] alloc_index;
	logic [lanes-1:0] complete_valid;
	rob_index_t [lanes-1:0] complete_index;
	logic [lanes-1:0] retire_valid;
	pc_t [lanes-1:0] retire_pc;
	logic [lanes-1:0] retire_dest_valid;
	arch_reg_t [lanes-1:0] retire_arch_reg;
	phys_reg_t [lanes-1:0] retire_preg;
	phys_reg_t [lanes-1:0] retire_told;
	logic [lanes-1:0] freed_valid;
	phys_reg_t [lanes-1:0] freed_preg;
	arch_reg_t lookup_arch_reg;
	phys_reg_t lookup_preg;

	int retired_total;
	bit saw_full;

	`include "rob_tb_model.svh"

	retire_subsystem u_retire_subsystem (.*);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#(timeout_cycles * clock_period);
		$display("run timed out after %0d cycles", timeout_cycles);
		$display("tests failed");
		$fatal(1);
	end

	// ##################################################
	// checks
	// ##################################################

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		assert (got === expected) else begin
			$display("** Error: %s is %0h, expected %0h", name, got, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_outputs();
		int accepted;
		int retiring;
		logic [lanes-1:0] exp_stall;
		logic [lanes-1:0] exp_retire;
		logic [lanes-1:0] exp_freed;
		accepted = model_accept_count(int'(dispatch_count));
		retiring = model_retire_count();
		exp_freed = '0;
		for (int i = 0; i < lanes; i++) begin
			exp_stall[i] = (i < int'(dispatch_count)) && (i >= accepted);
			exp_retire[i] = (i < retiring);
			if (exp_retire[i]) begin
				exp_freed[i] = model_queue[i].dest_valid;
			end
			check_value($sformatf("alloc_index[%0d]", i), alloc_index[i],
				rob_index_t'(model_tail + rob_index_t'(i)));
		end
		check_value("struct_stall", struct_stall, exp_stall);
		check_value("retire_valid", retire_valid, exp_retire);
		check_value("freed_valid", freed_valid, exp_freed);
		for (int j = 0; j < retiring; j++) begin
			check_value($sformatf("retire_pc[%0d]", j), retire_pc[j], model_queue[j].pc);
			check_value($sformatf("retire_dest_valid[%0d]", j), retire_dest_valid[j],
				model_queue[j].dest_valid);
			check_value($sformatf("retire_arch_reg[%0d]", j), retire_arch_reg[j],
				model_queue[j].arch_reg);
			check_value($sformatf("retire_preg[%0d]", j), retire_preg[j], model_queue[j].preg);
			check_value($sformatf("retire_told[%0d]", j), retire_told[j], model_queue[j].told);
			if (exp_freed[j]) begin
				check_value($sformatf("freed_preg[%0d]", j), freed_preg[j], model_queue[j].told);
			end
		end
		check_value("lookup_preg", lookup_preg, model_map[lookup_arch_reg]);
		if (model_queue.size() == rob_size && dispatch_count != 0) begin
			saw_full = 1'b1;
		end
	endtask

	// ##################################################
	// stimulus
	// ##################################################

	task automatic drive_stimulus(input int cycle);
		int pick;
		int open_pos [$];
		bit withhold;
		phys_reg_t preg;
		withhold = (cycle >= fill_start) && (cycle < fill_end);
		dispatch_count <= lane_count_t'($urandom_range(0, lanes));
		for (int i = 0; i < lanes; i++) begin
			preg = phys_reg_t'($urandom_range(0, phys_reg_count - 1));
			dispatch_pc[i] <= pc_t'($urandom);
			dispatch_dest_valid[i] <= ($urandom_range(0, 3) != 0);
			dispatch_arch_reg[i] <= arch_reg_t'($urandom_range(0, arch_reg_count - 1));
			dispatch_preg[i] <= preg;
			dispatch_told[i] <= preg + phys_reg_t'($urandom_range(1, phys_reg_count - 1));
		end
		for (int k = 0; k < model_queue.size(); k++) begin
			if (!model_queue[k].done) begin
				open_pos.push_back(k);
			end
		end
		for (int i = 0; i < lanes; i++) begin
			complete_valid[i] <= 1'b0;
			complete_index[i] <= rob_index_t'($urandom);
			if (!withhold && open_pos.size() != 0 && $urandom_range(0, 1) != 0) begin
				pick = $urandom_range(0, open_pos.size() - 1);
				complete_valid[i] <= 1'b1;
				complete_index[i] <= model_queue[open_pos[pick]].index;
				open_pos.delete(pick); // distinct indices per cycle.
			end
		end
		lookup_arch_reg <= arch_reg_t'($urandom_range(0, arch_reg_count - 1));
	endtask

	// what the DUT does at the coming edge.
	task automatic advance_model();
		int retiring;
		int accepted;
		model_entry_t entry;
		retiring = model_retire_count();
		accepted = model_accept_count(int'(dispatch_count));
		for (int i = 0; i < lanes; i++) begin
			if (complete_valid[i]) begin
				model_complete(complete_index[i]);
			end
		end
		model_retire(retiring);
		retired_total += retiring;
		for (int i = 0; i < accepted; i++) begin
			entry = '0;
			entry.pc = dispatch_pc[i];
			entry.dest_valid = dispatch_dest_valid[i];
			entry.arch_reg = dispatch_arch_reg[i];
			entry.preg = dispatch_preg[i];
			entry.told = dispatch_told[i];
			model_dispatch(entry);
		end
	endtask

	// ##################################################
	// run
	// ##################################################

	initial begin
		void'($urandom(seed));
		reset = 1'b1;
		dispatch_count = '0;
		dispatch_pc = '0;
		dispatch_dest_valid = '0;
		dispatch_arch_reg = '0;
		dispatch_preg = '0;
		dispatch_told = '0;
		complete_valid = '0;
		complete_index = '0;
		lookup_arch_reg = '0;
		retired_total = 0;
		saw_full = 1'b0;
		model_reset();
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("retire_valid", retire_valid, '0);
		check_value("freed_valid", freed_valid, '0);
		check_value("lookup_preg", lookup_preg, lookup_arch_reg);
		for (int cycle = 0; cycle < run_cycles; cycle++) begin
			@(posedge clock);
			drive_stimulus(cycle);
			@(negedge clock); // outputs settled.
			check_outputs();
			advance_model();
		end
		if (saw_full && retired_total > 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("stimulus never filled the buffer or never retired an entry");
			$display("tests failed");
			$fatal(1);
		end
	end

endmodule

// File: flist.f
+incdir+verification
common/rob_pkg.sv
rob/rob.sv
rtl/arch_map_table.sv
rtl/retire_subsystem.sv
verification/rob_tb.sv

// File: Bender.yml
package:
  name: retire_subsystem

sources:
  - files:
      - common/rob_pkg.sv
      - rob/rob.sv
      - rtl/arch_map_table.sv
      - rtl/retire_subsystem.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/rob_tb.sv
